/* Makefile */
# Verilator flow for the smem_queue testbench

TOP = tb_smem_queue

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* entry_ring.sv */
//==================================================
// 2*MAX_READ slots, no full check
// the pipeline must never hold more entries than that
//==================================================
`timescale 1ns/1ps

module entry_ring #(
	parameter int MAX_READ = 64
) (
	input  logic Clk_32UI,
	input  logic reset_n,
	input  logic stall,

	input  logic                                push,
	input  logic [smem_queue_pkg::ENTRY_W-1:0]  push_entry,
	input  logic                                pop,

	output logic [smem_queue_pkg::STATUS_W-1:0] head_status,
	output logic [smem_queue_pkg::ENTRY_W-1:0]  head_entry
);

	localparam int DEPTH = 2 * MAX_READ;
	localparam int AW    = $clog2(DEPTH);

	logic [smem_queue_pkg::ENTRY_W-1:0]  ring_mem   [DEPTH];
	logic [smem_queue_pkg::STATUS_W-1:0] status_mem [DEPTH]; // small copy for the head lookup

	logic [AW:0] wr_ptr; // extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic        empty;

	assign empty = (wr_ptr == rd_ptr);

	// storage
	always_ff @(posedge Clk_32UI) begin
		if (!stall && push) begin
			ring_mem[wr_ptr[AW-1:0]] <= push_entry;
			status_mem[wr_ptr[AW-1:0]] <=
				push_entry[smem_queue_pkg::OFS_STATUS +: smem_queue_pkg::STATUS_W];
		end
	end

	//==================================================
	// pointers
	//==================================================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (!stall) begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// head is visible as soon as it is written
	assign head_status = empty ? smem_queue_pkg::BUBBLE : status_mem[rd_ptr[AW-1:0]];
	assign head_entry  = ring_mem[rd_ptr[AW-1:0]];

endmodule

/* occ_fifo.sv */
//==================================================
// at most MAX_READ responses may be outstanding
// writes are taken even while stall is high
//==================================================
`timescale 1ns/1ps

module occ_fifo #(
	parameter int MAX_READ = 64
) (
	input  logic Clk_32UI,
	input  logic reset_n,
	input  logic dram_get,
	input  logic [smem_queue_pkg::OCC_W-1:0] occ_in,
	input  logic pop,
	input  logic stall,

	output logic                             occ_valid,
	output logic [smem_queue_pkg::OCC_W-1:0] occ_head
);

	localparam int AW    = (MAX_READ > 1) ? $clog2(MAX_READ) : 1;
	localparam int DEPTH = 1 << AW;

	logic [smem_queue_pkg::OCC_W-1:0] occ_mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	always_ff @(posedge Clk_32UI) begin
		if (dram_get) begin
			occ_mem[wr_ptr[AW-1:0]] <= occ_in;
		end
		if (!stall) begin
			occ_head <= occ_mem[rd_ptr[AW-1:0]]; // lines up with scheduler stage one
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (dram_get) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop && !stall) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	assign occ_valid = (wr_ptr != rd_ptr);

endmodule

/* query_align.sv */
//==================================================
// delay stages have no reset, they flush after
// QUERY_LAT+1 unstalled cycles of BUBBLE input
//==================================================
`timescale 1ns/1ps

module query_align #(
	parameter int QUERY_LAT = 3
) (
	input  logic Clk_32UI,
	input  logic stall,

	input  logic [smem_queue_pkg::STATUS_W-1:0]   status,
	input  logic [smem_queue_pkg::POS_W-1:0]      ptr_curr,
	input  logic [smem_queue_pkg::READ_NUM_W-1:0] read_num,
	input  logic [smem_queue_pkg::IK_W-1:0]       ik_x0,
	input  logic [smem_queue_pkg::IK_W-1:0]       ik_x1,
	input  logic [smem_queue_pkg::IK_W-1:0]       ik_x2,
	input  logic [smem_queue_pkg::INFO_W-1:0]     ik_info,
	input  logic [smem_queue_pkg::POS_W-1:0]      forward_i,
	input  logic [smem_queue_pkg::POS_W-1:0]      min_intv,
	input  logic [smem_queue_pkg::POS_W-1:0]      backward_x,

	input  logic [smem_queue_pkg::BASE_W-1:0]     new_read_query_2queue, // base from read RAM

	output logic                                  push,
	output logic [smem_queue_pkg::ENTRY_W-1:0]    push_entry
);

	logic [smem_queue_pkg::ENTRY_W-1:0] item_in;           // query field left at zero
	logic [smem_queue_pkg::ENTRY_W-1:0] dly [QUERY_LAT];
	logic [smem_queue_pkg::ENTRY_W-1:0] aligned;
	logic [smem_queue_pkg::STATUS_W-1:0] dly_status;

	// pack the incoming item into the ring layout
	always_comb begin
		item_in = '0;
		item_in[smem_queue_pkg::OFS_STATUS +: smem_queue_pkg::STATUS_W] = status;
		item_in[smem_queue_pkg::OFS_BACKWARD_X +: smem_queue_pkg::POS_W] = backward_x;
		item_in[smem_queue_pkg::OFS_MIN_INTV +: smem_queue_pkg::POS_W] = min_intv;
		item_in[smem_queue_pkg::OFS_FORWARD_I +: smem_queue_pkg::POS_W] = forward_i;
		item_in[smem_queue_pkg::OFS_IK_INFO +: smem_queue_pkg::INFO_W] = ik_info;
		item_in[smem_queue_pkg::OFS_IK_X2 +: smem_queue_pkg::IK_W] = ik_x2;
		item_in[smem_queue_pkg::OFS_IK_X1 +: smem_queue_pkg::IK_W] = ik_x1;
		item_in[smem_queue_pkg::OFS_IK_X0 +: smem_queue_pkg::IK_W] = ik_x0;
		item_in[smem_queue_pkg::OFS_READ_NUM +: smem_queue_pkg::READ_NUM_W] = read_num;
		item_in[smem_queue_pkg::OFS_PTR_CURR +: smem_queue_pkg::POS_W] = ptr_curr;
	end

	//==================================================
	// wait for the RAM query latency
	//==================================================
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			dly[0] <= item_in;
			for (int i = 1; i < QUERY_LAT; i++) begin
				dly[i] <= dly[i-1];
			end
		end
	end

	assign dly_status = dly[QUERY_LAT-1][smem_queue_pkg::OFS_STATUS +: smem_queue_pkg::STATUS_W];

	// base arrives together with the last stage
	always_comb begin
		aligned = dly[QUERY_LAT-1];
		aligned[smem_queue_pkg::OFS_QUERY +: smem_queue_pkg::BASE_W] = new_read_query_2queue;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			push_entry <= aligned;
			push <= (dly_status == smem_queue_pkg::F_RUN) ||
				(dly_status == smem_queue_pkg::F_BREAK); // F_INIT and BUBBLE dropped
		end
	end

endmodule

/* sim.f */
+incdir+.
smem_queue_pkg.sv
query_align.sv
entry_ring.sv
occ_fifo.sv
smem_scheduler.sv
smem_queue.sv
tb_smem_queue.sv

/* smem_queue.sv */
//==================================================
// forward-only queue, query port passes straight through
// RAM must answer exactly QUERY_LAT unstalled cycles later
//==================================================
`timescale 1ns/1ps

module smem_queue #(
	parameter int MAX_READ  = 64, // power of two, up to 64
	parameter int QUERY_LAT = 3
) (
	input  logic Clk_32UI,
	input  logic reset_n,
	input  logic stall,

	input  logic                                  dram_get,
	input  logic [smem_queue_pkg::OCC_W-1:0]      occ_in,

	// forward pipeline to queue
	input  logic [smem_queue_pkg::STATUS_W-1:0]   status,
	input  logic [smem_queue_pkg::POS_W-1:0]      ptr_curr,
	input  logic [smem_queue_pkg::READ_NUM_W-1:0] read_num,
	input  logic [smem_queue_pkg::IK_W-1:0]       ik_x0,
	input  logic [smem_queue_pkg::IK_W-1:0]       ik_x1,
	input  logic [smem_queue_pkg::IK_W-1:0]       ik_x2,
	input  logic [smem_queue_pkg::INFO_W-1:0]     ik_info,
	input  logic [smem_queue_pkg::POS_W-1:0]      forward_i,
	input  logic [smem_queue_pkg::POS_W-1:0]      min_intv,
	input  logic [smem_queue_pkg::POS_W-1:0]      backward_x,

	input  logic [smem_queue_pkg::POS_W-1:0]      next_query_position,
	input  logic [smem_queue_pkg::READ_NUM_W-1:0] read_num_query,
	input  logic [smem_queue_pkg::STATUS_W-1:0]   status_query,
	input  logic [smem_queue_pkg::BASE_W-1:0]     new_read_query_2queue,

	// queue to forward pipeline
	output logic [smem_queue_pkg::STATUS_W-1:0]   status_out_q,
	output logic [smem_queue_pkg::POS_W-1:0]      ptr_curr_out_q,
	output logic [smem_queue_pkg::READ_NUM_W-1:0] read_num_out_q,
	output logic [smem_queue_pkg::IK_W-1:0]       ik_x0_out_q,
	output logic [smem_queue_pkg::IK_W-1:0]       ik_x1_out_q,
	output logic [smem_queue_pkg::IK_W-1:0]       ik_x2_out_q,
	output logic [smem_queue_pkg::INFO_W-1:0]     ik_info_out_q,
	output logic [smem_queue_pkg::POS_W-1:0]      forward_i_out_q,
	output logic [smem_queue_pkg::POS_W-1:0]      min_intv_out_q,
	output logic [smem_queue_pkg::POS_W-1:0]      backward_x_out_q,
	output logic [smem_queue_pkg::BASE_W-1:0]     query_out_q,
	output logic [smem_queue_pkg::OCC_W-1:0]      cnt_out_q,

	// new read fetch
	output logic                                  new_read,
	input  logic                                  new_read_valid,
	input  logic [smem_queue_pkg::READ_NUM_W-1:0] new_read_num,
	input  logic [smem_queue_pkg::IK_W-1:0]       new_ik_x0,
	input  logic [smem_queue_pkg::IK_W-1:0]       new_ik_x1,
	input  logic [smem_queue_pkg::IK_W-1:0]       new_ik_x2,
	input  logic [smem_queue_pkg::INFO_W-1:0]     new_ik_info,
	input  logic [smem_queue_pkg::POS_W-1:0]      new_forward_i,
	input  logic [smem_queue_pkg::POS_W-1:0]      new_min_intv,

	output logic [smem_queue_pkg::POS_W-1:0]      query_position_2RAM,
	output logic [smem_queue_pkg::READ_NUM_W-1:0] query_read_num_2RAM,
	output logic [smem_queue_pkg::STATUS_W-1:0]   query_status_2RAM
);

	logic                                  push;
	logic [smem_queue_pkg::ENTRY_W-1:0]    push_entry;
	logic                                  ring_pop;
	logic [smem_queue_pkg::STATUS_W-1:0]   head_status;
	logic [smem_queue_pkg::ENTRY_W-1:0]    head_entry;
	logic                                  occ_pop;
	logic                                  occ_valid;
	logic [smem_queue_pkg::OCC_W-1:0]      occ_head;

	// query request goes to the read RAM untouched
	assign query_position_2RAM = next_query_position;
	assign query_read_num_2RAM = read_num_query;
	assign query_status_2RAM   = status_query;

	query_align #(.QUERY_LAT(QUERY_LAT)) u_align (
		.Clk_32UI, .stall, .status, .ptr_curr, .read_num,
		.ik_x0, .ik_x1, .ik_x2, .ik_info, .forward_i, .min_intv, .backward_x,
		.new_read_query_2queue, .push, .push_entry
	);

	entry_ring #(.MAX_READ(MAX_READ)) u_ring (
		.Clk_32UI, .reset_n, .stall, .push, .push_entry,
		.pop(ring_pop), .head_status, .head_entry
	);

	occ_fifo #(.MAX_READ(MAX_READ)) u_occ (
		.Clk_32UI, .reset_n, .dram_get, .occ_in,
		.pop(occ_pop), .stall, .occ_valid, .occ_head
	);

	smem_scheduler u_sched (
		.Clk_32UI, .reset_n, .stall, .head_status, .head_entry, .occ_valid, .occ_head,
		.new_read_valid, .new_read_num, .new_ik_x0, .new_ik_x1, .new_ik_x2,
		.new_ik_info, .new_forward_i, .new_min_intv,
		.ring_pop, .occ_pop, .new_read,
		.status_out_q, .ptr_curr_out_q, .read_num_out_q,
		.ik_x0_out_q, .ik_x1_out_q, .ik_x2_out_q, .ik_info_out_q,
		.forward_i_out_q, .min_intv_out_q, .backward_x_out_q, .query_out_q, .cnt_out_q
	);

endmodule

/* smem_queue_pkg.sv */
//==================================================
// status codes are one-hot, BUBBLE is all zero
// ring entry is packed LSB first, status in the low bits
//==================================================
package smem_queue_pkg;

	// status codes
	localparam int STATUS_W = 3;
	localparam logic [STATUS_W-1:0] BUBBLE  = 3'b000;
	localparam logic [STATUS_W-1:0] F_INIT  = 3'b001; // first round, no query needed
	localparam logic [STATUS_W-1:0] F_RUN   = 3'b010; // waits for a DRAM response
	localparam logic [STATUS_W-1:0] F_BREAK = 3'b100; // leaves without memory

	// field widths
	localparam int READ_NUM_W = 6;
	localparam int POS_W      = 7;
	localparam int IK_W       = 33;
	localparam int INFO_W     = 14; // two 7-bit halves
	localparam int BASE_W     = 8;
	localparam int CNT_W      = 32;
	localparam int OCC_W      = 4 * CNT_W; // cnt_a0 in the upper word

	//==================================================
	// ring entry layout
	//==================================================
	localparam int OFS_STATUS     = 0;
	localparam int OFS_BACKWARD_X = OFS_STATUS + STATUS_W;
	localparam int OFS_QUERY      = OFS_BACKWARD_X + POS_W;
	localparam int OFS_MIN_INTV   = OFS_QUERY + BASE_W;
	localparam int OFS_FORWARD_I  = OFS_MIN_INTV + POS_W;
	localparam int OFS_IK_INFO    = OFS_FORWARD_I + POS_W;
	localparam int OFS_IK_X2      = OFS_IK_INFO + INFO_W;
	localparam int OFS_IK_X1      = OFS_IK_X2 + IK_W;
	localparam int OFS_IK_X0      = OFS_IK_X1 + IK_W;
	localparam int OFS_READ_NUM   = OFS_IK_X0 + IK_W;
	localparam int OFS_PTR_CURR   = OFS_READ_NUM + READ_NUM_W;
	localparam int ENTRY_W        = OFS_PTR_CURR + POS_W; // 158 bits

endpackage

/* smem_scheduler.sv */
//==================================================
// one item per unstalled cycle, two register stages
// cnt_out_q is only meaningful for F_RUN items
//==================================================
`timescale 1ns/1ps

module smem_scheduler (
	input  logic Clk_32UI,
	input  logic reset_n,
	input  logic stall,

	input  logic [smem_queue_pkg::STATUS_W-1:0]   head_status,
	input  logic [smem_queue_pkg::ENTRY_W-1:0]    head_entry,
	input  logic                                  occ_valid,
	input  logic [smem_queue_pkg::OCC_W-1:0]      occ_head,

	input  logic                                  new_read_valid,
	input  logic [smem_queue_pkg::READ_NUM_W-1:0] new_read_num,
	input  logic [smem_queue_pkg::IK_W-1:0]       new_ik_x0,
	input  logic [smem_queue_pkg::IK_W-1:0]       new_ik_x1,
	input  logic [smem_queue_pkg::IK_W-1:0]       new_ik_x2,
	input  logic [smem_queue_pkg::INFO_W-1:0]     new_ik_info,
	input  logic [smem_queue_pkg::POS_W-1:0]      new_forward_i,
	input  logic [smem_queue_pkg::POS_W-1:0]      new_min_intv,

	output logic                                  ring_pop,
	output logic                                  occ_pop,
	output logic                                  new_read,

	output logic [smem_queue_pkg::STATUS_W-1:0]   status_out_q,
	output logic [smem_queue_pkg::POS_W-1:0]      ptr_curr_out_q,
	output logic [smem_queue_pkg::READ_NUM_W-1:0] read_num_out_q,
	output logic [smem_queue_pkg::IK_W-1:0]       ik_x0_out_q,
	output logic [smem_queue_pkg::IK_W-1:0]       ik_x1_out_q,
	output logic [smem_queue_pkg::IK_W-1:0]       ik_x2_out_q,
	output logic [smem_queue_pkg::INFO_W-1:0]     ik_info_out_q,
	output logic [smem_queue_pkg::POS_W-1:0]      forward_i_out_q,
	output logic [smem_queue_pkg::POS_W-1:0]      min_intv_out_q,
	output logic [smem_queue_pkg::POS_W-1:0]      backward_x_out_q,
	output logic [smem_queue_pkg::BASE_W-1:0]     query_out_q,
	output logic [smem_queue_pkg::OCC_W-1:0]      cnt_out_q
);

	logic take_break;
	logic take_run;
	logic take_new;

	// stage one
	logic [smem_queue_pkg::STATUS_W-1:0]   status_s1;
	logic [smem_queue_pkg::POS_W-1:0]      ptr_curr_s1;
	logic [smem_queue_pkg::READ_NUM_W-1:0] read_num_s1;
	logic [smem_queue_pkg::IK_W-1:0]       ik_x0_s1, ik_x1_s1, ik_x2_s1;
	logic [smem_queue_pkg::INFO_W-1:0]     ik_info_s1;
	logic [smem_queue_pkg::POS_W-1:0]      forward_i_s1, min_intv_s1, backward_x_s1;
	logic [smem_queue_pkg::BASE_W-1:0]     query_s1;

	//==================================================
	// priority: break, run with response, new read
	//==================================================
	assign take_break = (head_status == smem_queue_pkg::F_BREAK);
	assign take_run   = !take_break && occ_valid && (head_status == smem_queue_pkg::F_RUN);
	assign take_new   = !take_break && !occ_valid && new_read_valid;

	assign ring_pop = !stall && (take_break || take_run);
	assign occ_pop  = !stall && take_run;
	assign new_read = !stall && take_new;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			status_s1 <= smem_queue_pkg::BUBBLE;
		end else if (!stall) begin
			if (take_break || take_run) begin
				status_s1 <= head_status;
			end else if (take_new) begin
				status_s1 <= smem_queue_pkg::F_INIT;
			end else begin
				status_s1 <= smem_queue_pkg::BUBBLE;
			end
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			if (take_break || take_run) begin // unpack the ring head
				ptr_curr_s1   <= head_entry[smem_queue_pkg::OFS_PTR_CURR +: smem_queue_pkg::POS_W];
				read_num_s1   <= head_entry[smem_queue_pkg::OFS_READ_NUM +: smem_queue_pkg::READ_NUM_W];
				ik_x0_s1      <= head_entry[smem_queue_pkg::OFS_IK_X0 +: smem_queue_pkg::IK_W];
				ik_x1_s1      <= head_entry[smem_queue_pkg::OFS_IK_X1 +: smem_queue_pkg::IK_W];
				ik_x2_s1      <= head_entry[smem_queue_pkg::OFS_IK_X2 +: smem_queue_pkg::IK_W];
				ik_info_s1    <= head_entry[smem_queue_pkg::OFS_IK_INFO +: smem_queue_pkg::INFO_W];
				forward_i_s1  <= head_entry[smem_queue_pkg::OFS_FORWARD_I +: smem_queue_pkg::POS_W];
				min_intv_s1   <= head_entry[smem_queue_pkg::OFS_MIN_INTV +: smem_queue_pkg::POS_W];
				query_s1      <= head_entry[smem_queue_pkg::OFS_QUERY +: smem_queue_pkg::BASE_W];
				backward_x_s1 <= head_entry[smem_queue_pkg::OFS_BACKWARD_X +: smem_queue_pkg::POS_W];
			end else if (take_new) begin
				ptr_curr_s1   <= '0;
				read_num_s1   <= new_read_num;
				ik_x0_s1      <= new_ik_x0;
				ik_x1_s1      <= new_ik_x1;
				ik_x2_s1      <= new_ik_x2;
				ik_info_s1    <= new_ik_info;
				forward_i_s1  <= new_forward_i + 1'b1;
				min_intv_s1   <= new_min_intv;
				query_s1      <= '0;           // first round needs no query
				backward_x_s1 <= new_forward_i;
			end
		end
	end

	//==================================================
	// output stage
	//==================================================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			status_out_q <= smem_queue_pkg::BUBBLE;
		end else if (!stall) begin
			status_out_q <= status_s1;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			ptr_curr_out_q   <= ptr_curr_s1;
			read_num_out_q   <= read_num_s1;
			ik_x0_out_q      <= ik_x0_s1;
			ik_x1_out_q      <= ik_x1_s1;
			ik_x2_out_q      <= ik_x2_s1;
			ik_info_out_q    <= ik_info_s1;
			forward_i_out_q  <= forward_i_s1;
			min_intv_out_q   <= min_intv_s1;
			backward_x_out_q <= backward_x_s1;
			query_out_q      <= query_s1;
			cnt_out_q        <= occ_head; // already one stage behind the fifo
		end
	end

endmodule

/* tb_model.svh */
//==================================================
// testbench helpers, included inside tb_smem_queue
// an expected item packs every field, counts in the low 128 bits
//==================================================
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] next_rand();
	rng = xorshift(rng);
	return rng;
endfunction

function automatic logic [32:0] rand33();
	logic [31:0] a;
	logic [31:0] b;
	a = next_rand();
	b = next_rand();
	return {a[0], b};
endfunction

// read RAM contents, one base per read and position
function automatic logic [7:0] ram_query(input logic [5:0] rn, input logic [6:0] pos);
	logic [31:0] v;
	v = 32'(rn) * 32'd7 + 32'(pos);
	return v[7:0];
endfunction

function automatic logic [EXP_W-1:0] make_item(
	input logic [2:0] st, input logic [6:0] ptr, input logic [5:0] rn,
	input logic [32:0] x0, input logic [32:0] x1, input logic [32:0] x2,
	input logic [13:0] info, input logic [6:0] fi, input logic [6:0] mi,
	input logic [6:0] bx, input logic [7:0] q, input logic [127:0] cnt);
	return {st, ptr, rn, x0, x1, x2, info, fi, mi, bx, q, cnt};
endfunction

// new read enters as F_INIT, one step past its start position
function automatic logic [EXP_W-1:0] init_item(
	input logic [5:0] rn, input logic [32:0] x0, input logic [32:0] x1,
	input logic [32:0] x2, input logic [13:0] info, input logic [6:0] fi,
	input logic [6:0] mi);
	return make_item(smem_queue_pkg::F_INIT, 7'd0, rn, x0, x1, x2, info,
		fi + 7'd1, mi, fi, 8'd0, 128'd0);
endfunction

task automatic check(input string field, input logic [127:0] exp, input logic [127:0] act);
	if (exp !== act) begin
		$display("[FAIL] %s %s: expected %0h, actual %0h", test_name, field, exp, act);
		$display("Simulation finished: FAIL");
		$fatal(1);
	end
endtask

`endif

/* tb_smem_queue.sv */
//==================================================
// testbench for smem_queue, RAM model answers after QUERY_LAT
// unstalled cycles, phases drain before the next starts
//==================================================
`timescale 1ns/1ps

module tb_smem_queue;

	localparam int MAX_READ  = 64;
	localparam int QUERY_LAT = 3;
	localparam int EXP_W     = 286;

	localparam int RESET_N  = 5;
	localparam int INJ_N    = 12;
	localparam int BRK_N    = 24;
	localparam int RUN_N    = 6;
	localparam int RUN_WAIT = 12;
	localparam int STALL_N  = 6;
	localparam int DRAIN_N  = QUERY_LAT + 6;
	localparam int STIM_CYCLES = RESET_N + 4 + INJ_N + BRK_N + 2 * RUN_N + RUN_WAIT
		+ STALL_N + 12 + 4 * (DRAIN_N + 10);

	logic Clk_32UI, reset_n, stall, dram_get;
	logic [127:0] occ_in;
	logic [2:0]  status, status_query;
	logic [6:0]  ptr_curr, forward_i, min_intv, backward_x, next_query_position;
	logic [5:0]  read_num, read_num_query;
	logic [32:0] ik_x0, ik_x1, ik_x2;
	logic [13:0] ik_info;
	logic [7:0]  new_read_query_2queue;
	logic        new_read_valid, new_read;
	logic [5:0]  new_read_num;
	logic [32:0] new_ik_x0, new_ik_x1, new_ik_x2;
	logic [13:0] new_ik_info;
	logic [6:0]  new_forward_i, new_min_intv;
	logic [2:0]  status_out_q, query_status_2RAM;
	logic [6:0]  ptr_curr_out_q, forward_i_out_q, min_intv_out_q, backward_x_out_q;
	logic [6:0]  query_position_2RAM;
	logic [5:0]  read_num_out_q, query_read_num_2RAM;
	logic [32:0] ik_x0_out_q, ik_x1_out_q, ik_x2_out_q;
	logic [13:0] ik_info_out_q;
	logic [7:0]  query_out_q;
	logic [127:0] cnt_out_q;

	logic [31:0] rng = 32'h4f2;
	string test_name = "reset";
	logic [EXP_W-1:0] rec_q[$];   // F_BREAK and paired F_RUN, ring order
	logic [EXP_W-1:0] init_q[$];  // injected reads
	logic [EXP_W-1:0] run_q[$];   // F_RUN still waiting for a response
	logic [7:0] ram_dly [QUERY_LAT];

	`include "tb_model.svh"

	smem_queue #(.MAX_READ(MAX_READ), .QUERY_LAT(QUERY_LAT)) smem_queue_inst (.*);

	initial begin
		Clk_32UI = 1'b0;
		forever #4 Clk_32UI = ~Clk_32UI;
	end

	// read RAM, frozen by stall like the queue
	always @(posedge Clk_32UI) begin
		if (!stall) begin
			ram_dly[0] <= ram_query(query_read_num_2RAM, query_position_2RAM);
			for (int i = 1; i < QUERY_LAT; i++) begin
				ram_dly[i] <= ram_dly[i-1];
			end
		end
	end
	assign new_read_query_2queue = ram_dly[QUERY_LAT-1];

	task automatic step();
		@(posedge Clk_32UI);
		#1;
	endtask

	task automatic idle();
		status = smem_queue_pkg::BUBBLE;
		status_query = smem_queue_pkg::BUBBLE;
		dram_get = 1'b0;
		new_read_valid = 1'b0;
	endtask

	task automatic drive_item(input logic [2:0] st);
		logic [31:0] r;
		logic [6:0] pos;
		logic [EXP_W-1:0] item;
		r = next_rand();
		ptr_curr = r[6:0];
		read_num = r[12:7];
		forward_i = r[19:13];
		min_intv = r[26:20];
		r = next_rand();
		backward_x = r[6:0];
		pos = r[13:7];
		ik_info = r[27:14];
		ik_x0 = rand33();
		ik_x1 = rand33();
		ik_x2 = rand33();
		status = st;
		next_query_position = pos;
		read_num_query = read_num;
		status_query = st;
		item = make_item(st, ptr_curr, read_num, ik_x0, ik_x1, ik_x2, ik_info,
			forward_i, min_intv, backward_x, ram_query(read_num, pos), 128'd0);
		if (st == smem_queue_pkg::F_BREAK) begin
			rec_q.push_back(item);
		end else if (st == smem_queue_pkg::F_RUN) begin
			run_q.push_back(item);
		end
	endtask

	task automatic offer_new_read();
		logic [31:0] r;
		r = next_rand();
		new_read_num = r[5:0];
		new_forward_i = r[12:6];
		new_min_intv = r[19:13];
		new_ik_info = r[31:18];
		new_ik_x0 = rand33();
		new_ik_x1 = rand33();
		new_ik_x2 = rand33();
		new_read_valid = 1'b1;
	endtask

	task automatic expect_new_read();
		init_q.push_back(init_item(new_read_num, new_ik_x0, new_ik_x1, new_ik_x2,
			new_ik_info, new_forward_i, new_min_intv));
	endtask

	// pairs the oldest waiting F_RUN with a fresh response
	task automatic give_response();
		logic [EXP_W-1:0] item;
		occ_in = {next_rand(), next_rand(), next_rand(), next_rand()};
		dram_get = 1'b1;
		item = run_q.pop_front();
		item[127:0] = occ_in;
		rec_q.push_back(item);
	endtask

	task automatic drain();
		step(); // last driven values still reach the queue
		idle();
		while (rec_q.size() != 0 || init_q.size() != 0) begin
			step();
		end
		repeat (DRAIN_N) step();
	endtask

	task automatic compare_output();
		logic [EXP_W-1:0] e;
		logic [2:0] st;
		logic [6:0] ptr, fi, mi, bx;
		logic [5:0] rn;
		logic [32:0] x0, x1, x2;
		logic [13:0] info;
		logic [7:0] q;
		logic [127:0] cnt;
		if (status_out_q == smem_queue_pkg::F_INIT ? init_q.size() == 0 : rec_q.size() == 0) begin
			$display("%s: the queue emitted an item that was not expected", test_name);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
		e = (status_out_q == smem_queue_pkg::F_INIT) ? init_q.pop_front() : rec_q.pop_front();
		{st, ptr, rn, x0, x1, x2, info, fi, mi, bx, q, cnt} = e;
		check("status", 128'(st), 128'(status_out_q));
		check("ptr_curr", 128'(ptr), 128'(ptr_curr_out_q));
		check("read_num", 128'(rn), 128'(read_num_out_q));
		check("ik_x0", 128'(x0), 128'(ik_x0_out_q));
		check("ik_x1", 128'(x1), 128'(ik_x1_out_q));
		check("ik_x2", 128'(x2), 128'(ik_x2_out_q));
		check("ik_info", 128'(info), 128'(ik_info_out_q));
		check("forward_i", 128'(fi), 128'(forward_i_out_q));
		check("min_intv", 128'(mi), 128'(min_intv_out_q));
		check("backward_x", 128'(bx), 128'(backward_x_out_q));
		check("query", 128'(q), 128'(query_out_q));
		if (st == smem_queue_pkg::F_RUN) begin
			check("cnt", cnt, cnt_out_q);
		end
	endtask

	//==================================================
	// compare process, one item per unstalled edge
	//==================================================
	initial begin
		logic live;
		forever begin
			@(posedge Clk_32UI);
			live = !stall && reset_n;
			@(negedge Clk_32UI);
			check("query_status", 128'(status_query), 128'(query_status_2RAM));
			if (live && status_out_q != smem_queue_pkg::BUBBLE) begin
				compare_output();
			end
		end
	end

	initial begin
		#((4 * STIM_CYCLES + 200) * 8);
		$display("watchdog: the run did not finish in time, the queue seems to hang");
		$display("Simulation finished: FAIL");
		$fatal(1);
	end

	//==================================================
	// stimulus phases
	//==================================================
	initial begin
		logic [2:0] h_st;
		logic [5:0] h_rn;
		logic [7:0] h_q;
		logic [2:0] brk_sent [BRK_N];
		logic       brk_head;
		reset_n = 1'b0;
		stall = 1'b0;
		occ_in = '0;
		{ptr_curr, forward_i, min_intv, backward_x, next_query_position} = '0;
		{read_num, read_num_query, ik_x0, ik_x1, ik_x2, ik_info} = '0;
		{new_read_num, new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info} = '0;
		{new_forward_i, new_min_intv} = '0;
		idle();
		repeat (RESET_N) @(posedge Clk_32UI);
		#1;
		reset_n = 1'b1;
		repeat (4) begin
			step();
			check("status after reset", 128'(smem_queue_pkg::BUBBLE), 128'(status_out_q));
			check("new_read idle", 128'd0, 128'(new_read));
		end

		test_name = "injection";
		for (int i = 0; i < INJ_N; i++) begin
			step();
			offer_new_read();
			#1;
			check("new_read", 128'd1, 128'(new_read));
			expect_new_read();
		end
		drain();

		test_name = "f_break";
		for (int i = 0; i < BRK_N; i++) begin
			step();
			if (i % 5 == 4) begin
				brk_sent[i] = smem_queue_pkg::F_INIT; // dropped by the queue
			end else if (i % 3 == 2) begin
				brk_sent[i] = smem_queue_pkg::BUBBLE;
			end else begin
				brk_sent[i] = smem_queue_pkg::F_BREAK;
			end
			drive_item(brk_sent[i]);
			offer_new_read();
			#1;
			// break item is the ring head QUERY_LAT+2 cycles after it was driven
			brk_head = 1'b0;
			if (i >= QUERY_LAT + 2) begin
				brk_head = (brk_sent[i-QUERY_LAT-2] == smem_queue_pkg::F_BREAK);
			end
			check("new_read", 128'(!brk_head), 128'(new_read));
			if (!brk_head) begin
				expect_new_read();
			end
		end
		drain();

		test_name = "f_run";
		for (int i = 0; i < RUN_N; i++) begin
			step();
			drive_item(smem_queue_pkg::F_RUN);
		end
		step();
		idle();
		repeat (RUN_WAIT) step(); // nothing may come out yet
		for (int i = 0; i < RUN_N; i++) begin
			step();
			give_response();
		end
		drain();

		test_name = "stall";
		step();
		drive_item(smem_queue_pkg::F_RUN);
		step();
		drive_item(smem_queue_pkg::F_RUN);
		step();
		idle();
		repeat (QUERY_LAT + 3) step();
		h_st = status_out_q;
		h_rn = read_num_out_q;
		h_q = query_out_q;
		for (int i = 0; i < STALL_N; i++) begin
			step();
			stall = 1'b1;
			dram_get = 1'b0;
			drive_item((i % 2 == 0) ? smem_queue_pkg::F_INIT : smem_queue_pkg::BUBBLE);
			offer_new_read();
			if (i == 2) begin
				give_response(); // captured while stalled
			end
			#1;
			check("new_read in stall", 128'd0, 128'(new_read));
			check("held status", 128'(h_st), 128'(status_out_q));
			check("held read_num", 128'(h_rn), 128'(read_num_out_q));
			check("held query", 128'(h_q), 128'(query_out_q));
		end
		step();
		stall = 1'b0;
		idle();
		repeat (3) step();
		give_response();
		drain();

		if (run_q.size() == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("%0d F_RUN items never got a response", run_q.size());
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

endmodule
